// File: verilog/lpif_pkg.sv
`default_nettype none

package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Logic-link word and PHY channel widths

  localparam int LLINK_W  = 89;
  localparam int PHY_W    = 80;

  // LPIF field widths
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 64;
  localparam int CRC_W    = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Field offsets inside the logic-link word

  localparam int OFS_VALID     = 0;
  localparam int OFS_CRC_VALID = 1;
  localparam int OFS_CRC       = 2;
  localparam int OFS_DVALID    = 18;
  localparam int OFS_DATA      = 19;
  localparam int OFS_PROTID    = 83;
  localparam int OFS_STATE     = 85;

  ////////////////////////////////////////////////////////////////////////////
  // PHY channel layout

  // Word bits per channel payload
  localparam int CH_PAYLOAD_W = 45;
  // Word bits actually used by channel 1
  localparam int CH1_USED_W   = LLINK_W - CH_PAYLOAD_W;
  localparam int STB_BIT      = 78;
  localparam int MRK_BIT      = 79;
  // One marker per channel
  localparam int MRK_W        = 2;

  // Online delay values
  localparam int DELAY_W      = 8;

endpackage

`default_nettype wire

// File: verilog/lpif_sync_if.sv
`timescale 1ns/1ns
`default_nettype none

interface lpif_sync_if;
  import lpif_pkg::*;

  // Qualified online levels
  logic             tx_online;
  logic             rx_online;

  // Persistent user bits for the PHY frames
  logic [MRK_W-1:0] mrk_userbit;
  logic             stb_userbit;

  // Auto sync side
  modport src    (output tx_online, rx_online, mrk_userbit, stb_userbit);

  // PHY framing side
  modport tx_dst (input tx_online, mrk_userbit, stb_userbit);

  // Upstream unpack side
  modport rx_dst (input rx_online);

endinterface

`default_nettype wire

// File: verilog/ll_auto_sync.sv
`timescale 1ns/1ns
`default_nettype none

module ll_auto_sync (
  input  logic                         clk_wr,
  input  logic                         rst,

  // Raw online levels
  input  logic                         tx_online,
  input  logic                         rx_online,

  // Programmable qualification delays
  input  logic [lpif_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_xz_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_yz_value,

  lpif_sync_if.src                     sync
);
  import lpif_pkg::*;

  // Cycles rx_online sampled high
  logic [DELAY_W-1:0] x_cnt;
  logic [DELAY_W-1:0] x_cnt_nxt;
  // Cycles tx_online sampled high
  logic [DELAY_W-1:0] xz_cnt;
  logic [DELAY_W-1:0] xz_cnt_nxt;
  // Cycles qualified rx online has been high
  logic [DELAY_W-1:0] yz_cnt;
  logic [DELAY_W-1:0] yz_cnt_nxt;

  logic               rx_q;
  logic               rx_q_nxt;
  logic               tx_q;
  logic               tx_q_nxt;

  // Count up and hold at all ones
  function automatic logic [DELAY_W-1:0] sat_inc(input logic [DELAY_W-1:0] cnt);
    logic [DELAY_W-1:0] res;
    if (&cnt) begin
      res = cnt;
    end else begin
      res = cnt + DELAY_W'(1);
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Qualification counters

  always_comb begin
    // Receive side
    x_cnt_nxt  = rx_online ? sat_inc(x_cnt) : '0;
    rx_q_nxt   = rx_online && (x_cnt_nxt >= delay_x_value);

    // Transmit side, own level
    xz_cnt_nxt = tx_online ? sat_inc(xz_cnt) : '0;

    // Transmit side, time since receive came up
    yz_cnt_nxt = rx_q ? sat_inc(yz_cnt) : '0;

    // Both conditions, and receive must stay up on this edge too
    tx_q_nxt   = tx_online && rx_q && rx_q_nxt &&
                 (xz_cnt_nxt >= delay_xz_value) &&
                 (yz_cnt_nxt >= delay_yz_value);
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      x_cnt  <= '0;
      xz_cnt <= '0;
      yz_cnt <= '0;
      rx_q   <= 1'b0;
      tx_q   <= 1'b0;
    end else begin
      x_cnt  <= x_cnt_nxt;
      xz_cnt <= xz_cnt_nxt;
      yz_cnt <= yz_cnt_nxt;
      rx_q   <= rx_q_nxt;
      tx_q   <= tx_q_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs

  assign sync.rx_online   = rx_q;
  assign sync.tx_online   = tx_q;

  // Persistent strobe and marker while transmit is up
  assign sync.stb_userbit = tx_q;
  assign sync.mrk_userbit = {MRK_W{tx_q}};

  // Transmit never qualified without a qualified receive side
  a_tx_needs_rx: assert property (
    @(posedge clk_wr) disable iff (rst) tx_q |-> rx_q
  ) else $error("tx online qualified while rx online is low");

endmodule

`default_nettype wire

// File: verilog/lpif_txrx_x1_h1_master_name.sv
`timescale 1ns/1ns
`default_nettype none

module lpif_txrx_x1_h1_master_name (
  input  logic                          clk_wr,
  input  logic                          rst,
  input  logic                          m_gen2_mode,

  // Downstream LPIF beat
  input  logic [lpif_pkg::STATE_W-1:0]  dstrm_state,
  input  logic [lpif_pkg::PROTID_W-1:0] dstrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0]   dstrm_data,
  input  logic                          dstrm_dvalid,
  input  logic [lpif_pkg::CRC_W-1:0]    dstrm_crc,
  input  logic                          dstrm_crc_valid,
  input  logic                          dstrm_valid,

  // Upstream LPIF beat
  output logic [lpif_pkg::STATE_W-1:0]  ustrm_state,
  output logic [lpif_pkg::PROTID_W-1:0] ustrm_protid,
  output logic [lpif_pkg::DATA_W-1:0]   ustrm_data,
  output logic                          ustrm_dvalid,
  output logic [lpif_pkg::CRC_W-1:0]    ustrm_crc,
  output logic                          ustrm_crc_valid,
  output logic                          ustrm_valid,

  // Logic-link words
  output logic [lpif_pkg::LLINK_W-1:0]  tx_word,
  input  logic [lpif_pkg::LLINK_W-1:0]  rx_word,

  lpif_sync_if.rx_dst                   sync
);
  import lpif_pkg::*;

  logic [LLINK_W-1:0] tx_word_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Downstream pack

  always_comb begin
    tx_word_nxt                          = '0;
    tx_word_nxt[OFS_VALID]               = dstrm_valid;
    tx_word_nxt[OFS_DVALID]              = dstrm_dvalid;
    tx_word_nxt[OFS_DATA +: DATA_W]      = dstrm_data;
    tx_word_nxt[OFS_PROTID +: PROTID_W]  = dstrm_protid;
    tx_word_nxt[OFS_STATE +: STATE_W]    = dstrm_state;
    // CRC fields only carried in gen2
    if (m_gen2_mode) begin
      tx_word_nxt[OFS_CRC +: CRC_W]      = dstrm_crc;
      tx_word_nxt[OFS_CRC_VALID]         = dstrm_crc_valid;
    end
  end

  // One stage toward the PHY framing
  always_ff @(posedge clk_wr) begin
    tx_word <= tx_word_nxt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Upstream unpack

  always_ff @(posedge clk_wr) begin
    if (rst || !sync.rx_online) begin
      // Quiet upstream until receive is qualified
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else begin
      ustrm_state     <= rx_word[OFS_STATE +: STATE_W];
      ustrm_protid    <= rx_word[OFS_PROTID +: PROTID_W];
      ustrm_data      <= rx_word[OFS_DATA +: DATA_W];
      ustrm_dvalid    <= rx_word[OFS_DVALID];
      ustrm_valid     <= rx_word[OFS_VALID];
      // Gen1 reads CRC as zero
      ustrm_crc       <= m_gen2_mode ? rx_word[OFS_CRC +: CRC_W] : '0;
      ustrm_crc_valid <= m_gen2_mode & rx_word[OFS_CRC_VALID];
    end
  end

  // CRC valid only rises out of a gen2 cycle
  a_no_crc_gen1: assert property (
    @(posedge clk_wr) disable iff (rst)
      $rose(ustrm_crc_valid) |-> $past(m_gen2_mode)
  ) else $error("ustrm_crc_valid rose in gen1 mode");

endmodule

`default_nettype wire

// File: verilog/lpif_txrx_x1_h1_master_concat.sv
`timescale 1ns/1ns
`default_nettype none

module lpif_txrx_x1_h1_master_concat (
  input  logic                         clk_wr,
  input  logic                         rst,

  // Logic-link words
  input  logic [lpif_pkg::LLINK_W-1:0] tx_word,
  output logic [lpif_pkg::LLINK_W-1:0] rx_word,

  // PHY channels
  output logic [lpif_pkg::PHY_W-1:0]   tx_phy0,
  output logic [lpif_pkg::PHY_W-1:0]   tx_phy1,
  input  logic [lpif_pkg::PHY_W-1:0]   rx_phy0,
  input  logic [lpif_pkg::PHY_W-1:0]   rx_phy1,

  lpif_sync_if.tx_dst                  sync
);
  import lpif_pkg::*;

  logic [CH_PAYLOAD_W-1:0] ch0_payload;
  logic [CH_PAYLOAD_W-1:0] ch1_payload;
  logic                    rx_stb_ok;
  logic [LLINK_W-1:0]      rx_word_nxt;

  // One channel frame
  // payload in the low bits, strobe and marker on top
  function automatic logic [PHY_W-1:0] build_frame(
    input logic [CH_PAYLOAD_W-1:0] payload,
    input logic                    stb,
    input logic                    mrk
  );
    logic [PHY_W-1:0] frame;
    frame                     = '0;
    frame[CH_PAYLOAD_W-1:0]   = payload;
    frame[STB_BIT]            = stb;
    frame[MRK_BIT]            = mrk;
    return frame;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transmit split

  // Channel 0 gets the low word bits
  assign ch0_payload = tx_word[CH_PAYLOAD_W-1:0];

  // Channel 1 gets the rest, top payload bit padded with zero
  assign ch1_payload = {{(CH_PAYLOAD_W - CH1_USED_W){1'b0}},
                        tx_word[CH_PAYLOAD_W +: CH1_USED_W]};

  always_ff @(posedge clk_wr) begin
    if (rst || !sync.tx_online) begin
      // Idle PHY until transmit is qualified
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= build_frame(ch0_payload, sync.stb_userbit, sync.mrk_userbit[0]);
      tx_phy1 <= build_frame(ch1_payload, sync.stb_userbit, sync.mrk_userbit[1]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive join

  // Both channels must show strobe
  assign rx_stb_ok = rx_phy0[STB_BIT] & rx_phy1[STB_BIT];

  always_comb begin
    if (rx_stb_ok) begin
      rx_word_nxt = {rx_phy1[CH1_USED_W-1:0], rx_phy0[CH_PAYLOAD_W-1:0]};
    end else begin
      rx_word_nxt = '0;
    end
  end

  // One stage toward upstream unpack
  always_ff @(posedge clk_wr) begin
    rx_word <= rx_word_nxt;
  end

  // Offline transmit leaves both channels idle on the next cycle
  a_tx_idle_offline: assert property (
    @(posedge clk_wr) disable iff (rst)
      !sync.tx_online |=> (tx_phy0 == '0) && (tx_phy1 == '0)
  ) else $error("tx_phy active after tx online was low");

endmodule

`default_nettype wire

// File: verilog/lpif_txrx_x1_h1_master_top.sv
`timescale 1ns/1ns
`default_nettype none

module lpif_txrx_x1_h1_master_top (
  input  logic                          clk_wr,
  input  logic                          rst,

  // Raw online levels
  input  logic                          tx_online,
  input  logic                          rx_online,

  // Online qualification delays
  input  logic [lpif_pkg::DELAY_W-1:0]  delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0]  delay_xz_value,
  input  logic [lpif_pkg::DELAY_W-1:0]  delay_yz_value,

  input  logic                          m_gen2_mode,

  // PHY channels
  output logic [lpif_pkg::PHY_W-1:0]    tx_phy0,
  input  logic [lpif_pkg::PHY_W-1:0]    rx_phy0,
  output logic [lpif_pkg::PHY_W-1:0]    tx_phy1,
  input  logic [lpif_pkg::PHY_W-1:0]    rx_phy1,

  // Downstream LPIF
  input  logic [lpif_pkg::STATE_W-1:0]  dstrm_state,
  input  logic [lpif_pkg::PROTID_W-1:0] dstrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0]   dstrm_data,
  input  logic                          dstrm_dvalid,
  input  logic [lpif_pkg::CRC_W-1:0]    dstrm_crc,
  input  logic                          dstrm_crc_valid,
  input  logic                          dstrm_valid,

  // Upstream LPIF
  output logic [lpif_pkg::STATE_W-1:0]  ustrm_state,
  output logic [lpif_pkg::PROTID_W-1:0] ustrm_protid,
  output logic [lpif_pkg::DATA_W-1:0]   ustrm_data,
  output logic                          ustrm_dvalid,
  output logic [lpif_pkg::CRC_W-1:0]    ustrm_crc,
  output logic                          ustrm_crc_valid,
  output logic                          ustrm_valid
);
  import lpif_pkg::*;

  // Logic-link words between unpack and PHY framing
  logic [LLINK_W-1:0] tx_word;
  logic [LLINK_W-1:0] rx_word;

  lpif_sync_if sync_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Online qualification

  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .sync            (sync_if.src)
  );

  ////////////////////////////////////////////////////////////////////////////
  // LPIF field mapping

  lpif_txrx_x1_h1_master_name lpif_txrx_x1_h1_master_name_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .m_gen2_mode     (m_gen2_mode),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .sync            (sync_if.rx_dst)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PHY framing

  lpif_txrx_x1_h1_master_concat lpif_txrx_x1_h1_master_concat_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .sync            (sync_if.tx_dst)
  );

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk_wr,
  output logic rst
);

  // 40 ns period, low phase first
  initial begin
    clk_wr = 1'b0;
    forever begin
      #20 clk_wr = ~clk_wr;
    end
  end

  // Held over the first three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk_wr);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: test/tb_lpif_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lpif_top;
  import lpif_pkg::*;

  logic                clk_wr;
  logic                rst;
  logic                tx_online = 1'b0;
  logic                rx_online = 1'b0;
  logic [DELAY_W-1:0]  delay_x_value = 8'd6;
  logic [DELAY_W-1:0]  delay_xz_value = 8'd4;
  logic [DELAY_W-1:0]  delay_yz_value = 8'd5;
  logic                m_gen2_mode = 1'b1;
  logic [PHY_W-1:0]    tx_phy0;
  logic [PHY_W-1:0]    tx_phy1;
  logic [PHY_W-1:0]    rx_phy0;
  logic [PHY_W-1:0]    rx_phy1;
  logic [STATE_W-1:0]  dstrm_state = '0;
  logic [PROTID_W-1:0] dstrm_protid = '0;
  logic [DATA_W-1:0]   dstrm_data = '0;
  logic                dstrm_dvalid = 1'b0;
  logic [CRC_W-1:0]    dstrm_crc = '0;
  logic                dstrm_crc_valid = 1'b0;
  logic                dstrm_valid = 1'b0;
  logic [STATE_W-1:0]  ustrm_state;
  logic [PROTID_W-1:0] ustrm_protid;
  logic [DATA_W-1:0]   ustrm_data;
  logic                ustrm_dvalid;
  logic [CRC_W-1:0]    ustrm_crc;
  logic                ustrm_crc_valid;
  logic                ustrm_valid;

  int                  seed = 32'hc91c_3bb3;
  logic [31:0]         rnd_a;
  logic [31:0]         rnd_b;
  logic [31:0]         rnd_c;
  int                  errors = 0;
  int                  beats = 0;
  int                  cyc = 0;

  // Expected words, index 0 newest
  logic [LLINK_W-1:0]  hist [0:3];
  logic [LLINK_W-1:0]  exp_word;
  logic [PHY_W-1:0]    exp_phy0;
  logic [PHY_W-1:0]    exp_phy1;
  // Online reference
  int                  rx_run;
  int                  tx_run;
  int                  rxq_run;
  logic                rx_up;
  logic                rx_up_d;
  logic [3:0]          tx_up_h;
  logic                gen2_d;
  logic                rx_now;
  logic                tx_now;

  tb_clkgen clkgen (
    .clk_wr (clk_wr),
    .rst    (rst)
  );

  // PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  lpif_txrx_x1_h1_master_top uut (.*);

  // Payload low, then 33 idle bits, strobe at 78, marker at 79
  function automatic logic [PHY_W-1:0] phy_frame(input logic [44:0] payload);
    return {2'b11, 33'h0, payload};
  endfunction

  task automatic check_value(input string name, input logic [LLINK_W-1:0] exp,
                             input logic [LLINK_W-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Receive up first, transmit a few cycles later
  task automatic bring_up_link();
    int t_rx;
    int t_tx;
    int seen;
    @(posedge clk_wr);
    rx_online <= 1'b1;
    t_rx = cyc;
    repeat (3) @(posedge clk_wr);
    tx_online <= 1'b1;
    t_tx = cyc;
    do begin
      @(negedge clk_wr);
    end while (!tx_phy0[STB_BIT]);
    seen = cyc;
    assert ((seen - t_rx > int'(delay_x_value) + int'(delay_yz_value)) &&
            (seen - t_tx > int'(delay_xz_value))) else begin
      errors++;
      $display("transmit came online before its delays ran out, cycle %0d", seen);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, a fresh random beat every cycle

  always @(posedge clk_wr) begin
    rnd_a = $random(seed);
    rnd_b = $random(seed);
    rnd_c = $random(seed);
    dstrm_data      <= {rnd_a, rnd_b};
    dstrm_crc       <= rnd_c[15:0];
    dstrm_state     <= rnd_c[19:16];
    dstrm_protid    <= rnd_c[21:20];
    dstrm_dvalid    <= rnd_c[22];
    dstrm_crc_valid <= rnd_c[23];
    dstrm_valid     <= rnd_c[24];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  assign rx_now = rx_online && (rx_run + 1 >= int'(delay_x_value));
  assign tx_now = tx_online && rx_up && rx_now &&
                  (tx_run + 1 >= int'(delay_xz_value)) &&
                  (rxq_run + 1 >= int'(delay_yz_value));

  always @(posedge clk_wr) begin
    // State on top down to valid in bit 0, CRC dropped in gen1
    hist[0] <= {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                m_gen2_mode ? dstrm_crc : CRC_W'(0),
                dstrm_crc_valid & m_gen2_mode, dstrm_valid};
    hist[1] <= hist[0];
    hist[2] <= hist[1];
    hist[3] <= hist[2];
    gen2_d  <= m_gen2_mode;
    if (rst) begin
      rx_run  <= 0;
      tx_run  <= 0;
      rxq_run <= 0;
      rx_up   <= 1'b0;
      rx_up_d <= 1'b0;
      tx_up_h <= '0;
    end else begin
      rx_run  <= rx_online ? rx_run + 1 : 0;
      tx_run  <= tx_online ? tx_run + 1 : 0;
      rxq_run <= rx_up ? rxq_run + 1 : 0;
      rx_up   <= rx_now;
      rx_up_d <= rx_up;
      tx_up_h <= {tx_up_h[2:0], tx_now};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks, mid-cycle where outputs are stable

  always @(negedge clk_wr) begin
    if (!rst) begin
      // PHY frames trail the word by one stage
      exp_phy0 = tx_up_h[1] ? phy_frame(hist[1][44:0]) : '0;
      exp_phy1 = tx_up_h[1] ? phy_frame({1'b0, hist[1][88:45]}) : '0;
      check_value("tx_phy0", LLINK_W'(exp_phy0), LLINK_W'(tx_phy0));
      check_value("tx_phy1", LLINK_W'(exp_phy1), LLINK_W'(tx_phy1));
      // Upstream needs strobes two stages back and rx up one back
      exp_word = (rx_up_d && tx_up_h[3]) ? hist[3] : '0;
      if (!gen2_d) begin
        exp_word[17:1] = '0;
      end
      if (rx_up_d && tx_up_h[3]) begin
        beats++;
      end
      check_value("ustrm_state", LLINK_W'(exp_word[88:85]), LLINK_W'(ustrm_state));
      check_value("ustrm_protid", LLINK_W'(exp_word[84:83]), LLINK_W'(ustrm_protid));
      check_value("ustrm_data", LLINK_W'(exp_word[82:19]), LLINK_W'(ustrm_data));
      check_value("ustrm_dvalid", LLINK_W'(exp_word[18]), LLINK_W'(ustrm_dvalid));
      check_value("ustrm_crc", LLINK_W'(exp_word[17:2]), LLINK_W'(ustrm_crc));
      check_value("ustrm_crc_valid", LLINK_W'(exp_word[1]), LLINK_W'(ustrm_crc_valid));
      check_value("ustrm_valid", LLINK_W'(exp_word[0]), LLINK_W'(ustrm_valid));
    end
  end

  // Active frames carry strobe and marker on both channels
  a_frame_bits: assert property (@(posedge clk_wr) disable iff (rst)
    (tx_phy0 != '0) |-> (tx_phy0[MRK_BIT:STB_BIT] == 2'b11) &&
                        (tx_phy1[MRK_BIT:STB_BIT] == 2'b11)
  ) else begin
    errors++;
    $display("active PHY frame at %0t ns without strobe and marker", $time);
  end

  // Run limit, tests take about 1200 cycles
  always @(posedge clk_wr) begin
    cyc <= cyc + 1;
    if (cyc >= 2000) begin
      $display("timeout: test sequence still running after %0d cycles", cyc);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    do begin
      @(posedge clk_wr);
    end while (rst);
    // Links down, outputs must stay quiet
    repeat (10) @(posedge clk_wr);
    bring_up_link();
    // Gen2 streaming
    repeat (600) @(posedge clk_wr);
    // Gen1, CRC fields dropped
    m_gen2_mode <= 1'b0;
    repeat (500) @(posedge clk_wr);
    // Offline, transmit first
    tx_online <= 1'b0;
    repeat (8) @(posedge clk_wr);
    // Transmit back up, then receive drops with beats in flight
    tx_online <= 1'b1;
    repeat (20) @(posedge clk_wr);
    rx_online <= 1'b0;
    repeat (8) @(posedge clk_wr);
    assert (beats > 1000) else begin
      errors++;
      $display("too few beats reached the upstream side: %0d", beats);
    end
    $display("errors: %0d, beats checked: %0d, cycles: %0d", errors, beats, cyc);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
verilog/lpif_pkg.sv
verilog/lpif_sync_if.sv
verilog/ll_auto_sync.sv
verilog/lpif_txrx_x1_h1_master_name.sv
verilog/lpif_txrx_x1_h1_master_concat.sv
verilog/lpif_txrx_x1_h1_master_top.sv
test/tb_clkgen.sv
test/tb_lpif_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lpif_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
